// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes, instruction bits 6:2
  localparam logic [4:0] opc_load   = 5'b00000;
  localparam logic [4:0] opc_store  = 5'b01000;
  localparam logic [4:0] opc_branch = 5'b11000;
  localparam logic [4:0] opc_jal    = 5'b11011;
  localparam logic [4:0] opc_jalr   = 5'b11001;
  localparam logic [4:0] opc_lui    = 5'b01101;
  localparam logic [4:0] opc_auipc  = 5'b00101;
  localparam logic [4:0] opc_op_imm = 5'b00100;
  localparam logic [4:0] opc_op     = 5'b01100;

  // low two bits of every 32-bit encoding
  localparam logic [1:0] len_32 = 2'b11;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // alu funct3
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load/store width funct3, jalr takes only 000
  localparam logic [2:0] f3_byte  = 3'b000;
  localparam logic [2:0] f3_half  = 3'b001;
  localparam logic [2:0] f3_word  = 3'b010;
  localparam logic [2:0] f3_byteu = 3'b100;
  localparam logic [2:0] f3_halfu = 3'b101;
  localparam logic [2:0] f3_jalr  = 3'b000;

  localparam word_t inst_len = 32'd4;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [4:0] opcode;
    logic [1:0] len;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [4:0]  opcode;
    logic [1:0]  len;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [4:0] opcode;
    logic [1:0] len;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [4:0] opcode;
    logic [1:0] len;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    logic [4:0]  opcode;
    logic [1:0]  len;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [4:0] opcode;
    logic [1:0] len;
  } j_fmt_t;

  // one instruction word, six views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

endpackage

`default_nettype wire

// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

  import rv_isa_pkg::*;

  // operations seen by the executor, branches carry op_none
  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_lui,
    op_lb,
    op_lh,
    op_lw,
    op_lbu,
    op_lhu,
    op_sb,
    op_sh,
    op_sw,
    op_none
  } dec_op_e;

  typedef enum logic [2:0] {
    fmt_i,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j,
    fmt_none
  } imm_fmt_e;

  // branch condition comes from funct3
  typedef enum logic [2:0] {
    ctrl_seq,
    ctrl_jal,
    ctrl_jalr,
    ctrl_branch
  } ctrl_kind_e;

  typedef struct packed {
    instr_u instr;
    word_t  pc;
  } fetch_t;

  typedef struct packed {
    dec_op_e    op;
    imm_fmt_e   imm_fmt;
    ctrl_kind_e ctrl;
    logic [2:0] funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       use_imm;
    logic       shift_imm;
    logic       is_mem;
    logic       valid_instr;
  } class_t;

  typedef struct packed {
    dec_op_e  op;
    reg_idx_t rd;
    word_t    operand_a;
    word_t    operand_b;
    word_t    mem_addr;
    logic     valid_instr;
  } decoded_t;

endpackage

`default_nettype wire

// File: instr_classifier.sv
`default_nettype none

module instr_classifier
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input  instr_u instr,
  output class_t cls
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt_legal;
  logic       needs_f7;
  logic       alu_ok;
  dec_op_e    alu_op;

  assign opcode = instr.r.opcode;
  assign funct3 = instr.r.funct3;
  assign funct7 = instr.r.funct7;

  // funct7 is only checked where it selects something
  assign alt_legal = funct3 == f3_sr || (funct3 == f3_add && opcode == opc_op);
  assign needs_f7  = opcode == opc_op || funct3 == f3_sll || funct3 == f3_sr;
  assign alu_ok    = !needs_f7 || funct7 == funct7_base ||
                     (funct7 == funct7_alt && alt_legal);

  // OP and OP-IMM share the funct3 map
  always_comb begin
    unique case (funct3)
      f3_add:  alu_op = (opcode == opc_op && funct7 == funct7_alt) ? op_sub : op_add;
      f3_sll:  alu_op = op_sll;
      f3_slt:  alu_op = op_slt;
      f3_sltu: alu_op = op_sltu;
      f3_xor:  alu_op = op_xor;
      f3_sr:   alu_op = (funct7 == funct7_alt) ? op_sra : op_srl;
      f3_or:   alu_op = op_or;
      default: alu_op = op_and;
    endcase
  end

  always_comb begin
    cls.op          = op_none;
    cls.imm_fmt     = fmt_none;
    cls.ctrl        = ctrl_seq;
    cls.funct3      = funct3;
    cls.rd          = instr.r.rd;
    cls.rs1         = instr.r.rs1;
    cls.rs2         = instr.r.rs2;
    cls.use_imm     = 1'b0;
    cls.shift_imm   = 1'b0;
    cls.is_mem      = 1'b0;
    cls.valid_instr = 1'b0;

    if (instr.r.len == len_32) begin
      unique case (opcode)
        opc_lui: begin
          cls.op          = op_lui;
          cls.imm_fmt     = fmt_u;
          cls.use_imm     = 1'b1;
          cls.valid_instr = 1'b1;
        end
        opc_auipc: begin
          cls.op          = op_add;
          cls.imm_fmt     = fmt_u;
          cls.use_imm     = 1'b1;
          cls.valid_instr = 1'b1;
        end
        opc_jal: begin
          cls.op          = op_add;
          cls.imm_fmt     = fmt_j;
          cls.ctrl        = ctrl_jal;
          cls.valid_instr = 1'b1;
        end
        opc_jalr: begin
          cls.op          = op_add;
          cls.imm_fmt     = fmt_i;
          cls.ctrl        = ctrl_jalr;
          cls.valid_instr = funct3 == f3_jalr;
        end
        opc_branch: begin
          cls.imm_fmt     = fmt_b;
          cls.ctrl        = ctrl_branch;
          cls.rd          = '0;
          cls.valid_instr = funct3 != 3'b010 && funct3 != 3'b011;
        end
        opc_load: begin
          cls.imm_fmt     = fmt_i;
          cls.is_mem      = 1'b1;
          cls.valid_instr = 1'b1;
          unique case (funct3)
            f3_byte:  cls.op = op_lb;
            f3_half:  cls.op = op_lh;
            f3_word:  cls.op = op_lw;
            f3_byteu: cls.op = op_lbu;
            f3_halfu: cls.op = op_lhu;
            default:  cls.valid_instr = 1'b0;
          endcase
        end
        opc_store: begin
          cls.imm_fmt     = fmt_s;
          cls.is_mem      = 1'b1;
          cls.rd          = '0;
          cls.valid_instr = 1'b1;
          unique case (funct3)
            f3_byte: cls.op = op_sb;
            f3_half: cls.op = op_sh;
            f3_word: cls.op = op_sw;
            default: cls.valid_instr = 1'b0;
          endcase
        end
        opc_op_imm: begin
          cls.op          = alu_op;
          cls.imm_fmt     = fmt_i;
          cls.use_imm     = 1'b1;
          cls.shift_imm   = funct3 == f3_sll || funct3 == f3_sr;
          cls.valid_instr = alu_ok;
        end
        opc_op: begin
          cls.op          = alu_op;
          cls.valid_instr = alu_ok;
        end
        default: cls.valid_instr = 1'b0;
      endcase
    end

    // anything unlisted leaves as a sequential no-op
    if (!cls.valid_instr) begin
      cls.op        = op_none;
      cls.imm_fmt   = fmt_none;
      cls.ctrl      = ctrl_seq;
      cls.rd        = '0;
      cls.use_imm   = 1'b0;
      cls.shift_imm = 1'b0;
      cls.is_mem    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: imm_gen.sv
`default_nettype none

module imm_gen
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input  instr_u   instr,
  input  imm_fmt_e fmt,
  input  logic     shift_imm,
  output word_t    imm
);

  word_t fmt_imm;

  always_comb begin
    unique case (fmt)
      fmt_i: fmt_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      fmt_s: fmt_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      fmt_b: begin
        fmt_imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                   instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      fmt_u: fmt_imm = {instr.u.imm_31_12, 12'b0};
      fmt_j: begin
        fmt_imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                   instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      default: fmt_imm = '0;
    endcase
  end

  // shamt sits in the low five bits of the I immediate
  assign imm = shift_imm ? {27'b0, instr.i.imm[4:0]} : fmt_imm;

endmodule

`default_nettype wire

// File: branch_unit.sv
`default_nettype none

module branch_unit
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input  word_t      fetch_pc,
  input  ctrl_kind_e ctrl,
  input  logic [2:0] funct3,
  input  word_t      imm,
  input  word_t      reg_rs1,
  input  word_t      reg_rs2,
  output word_t      target_pc
);

  word_t seq_pc;
  word_t rel_pc;
  word_t jalr_sum;
  logic  taken;

  assign seq_pc   = fetch_pc + inst_len;
  assign rel_pc   = fetch_pc + imm;
  assign jalr_sum = reg_rs1 + imm;

  always_comb begin
    unique case (funct3)
      f3_beq:  taken = reg_rs1 == reg_rs2;
      f3_bne:  taken = reg_rs1 != reg_rs2;
      f3_blt:  taken = $signed(reg_rs1) < $signed(reg_rs2);
      f3_bge:  taken = $signed(reg_rs1) >= $signed(reg_rs2);
      f3_bltu: taken = reg_rs1 < reg_rs2;
      f3_bgeu: taken = reg_rs1 >= reg_rs2;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    unique case (ctrl)
      ctrl_jal:    target_pc = rel_pc;
      // jalr drops bit 0 of the sum
      ctrl_jalr:   target_pc = {jalr_sum[xlen-1:1], 1'b0};
      ctrl_branch: target_pc = taken ? rel_pc : seq_pc;
      default:     target_pc = seq_pc;
    endcase
  end

endmodule

`default_nettype wire

// File: decode_stage_reg.sv
`default_nettype none

module decode_stage_reg
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     fetch_valid,
  output logic     fetch_ready,
  input  word_t    fetch_pc,
  input  class_t   cls,
  input  word_t    imm,
  input  word_t    reg_rs1,
  input  word_t    reg_rs2,
  input  word_t    target_pc,
  output logic     dec_valid,
  input  logic     exec_ready,
  output decoded_t dec,
  output word_t    next_pc
);

  logic  accept;
  logic  is_jump;
  word_t operand_a;
  word_t operand_b;
  word_t mem_addr;

  // the held item may leave in the same cycle a new one enters
  assign fetch_ready = !dec_valid || exec_ready;
  assign accept      = fetch_valid && fetch_ready;
  assign is_jump     = cls.ctrl == ctrl_jal || cls.ctrl == ctrl_jalr;

  always_comb begin
    operand_a = reg_rs1;
    operand_b = cls.use_imm ? imm : reg_rs2;
    if (!cls.valid_instr || cls.ctrl == ctrl_branch) begin
      operand_a = '0;
      operand_b = '0;
    end else if (is_jump) begin
      // link value pc + 4
      operand_a = fetch_pc;
      operand_b = inst_len;
    end else if (cls.op == op_lui) begin
      operand_a = '0;
    end else if (cls.imm_fmt == fmt_u) begin
      // auipc
      operand_a = fetch_pc;
    end
  end

  assign mem_addr = cls.is_mem ? reg_rs1 + imm : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
      next_pc   <= '0;
    end else begin
      if (fetch_ready) begin
        dec_valid <= fetch_valid;
      end
      if (accept) begin
        next_pc <= target_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec.op          <= cls.op;
      dec.rd          <= cls.rd;
      dec.operand_a   <= operand_a;
      dec.operand_b   <= operand_b;
      dec.mem_addr    <= mem_addr;
      dec.valid_instr <= cls.valid_instr;
    end
  end

endmodule

`default_nettype wire

// File: rv32_decoder.sv
`default_nettype none

module rv32_decoder
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     fetch_valid,
  output logic     fetch_ready,
  input  fetch_t   fetch,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  input  word_t    reg_rs1,
  input  word_t    reg_rs2,
  output logic     dec_valid,
  input  logic     exec_ready,
  output decoded_t dec,
  output word_t    next_pc
);

  class_t cls;
  word_t  imm;
  word_t  target_pc;

  // register file reads go straight out
  assign rs1 = cls.rs1;
  assign rs2 = cls.rs2;

  instr_classifier u_classifier (
    .instr (fetch.instr),
    .cls   (cls)
  );

  imm_gen u_imm_gen (
    .instr     (fetch.instr),
    .fmt       (cls.imm_fmt),
    .shift_imm (cls.shift_imm),
    .imm       (imm)
  );

  branch_unit u_branch_unit (
    .fetch_pc  (fetch.pc),
    .ctrl      (cls.ctrl),
    .funct3    (cls.funct3),
    .imm       (imm),
    .reg_rs1   (reg_rs1),
    .reg_rs2   (reg_rs2),
    .target_pc (target_pc)
  );

  decode_stage_reg u_stage (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch.pc),
    .cls         (cls),
    .imm         (imm),
    .reg_rs1     (reg_rs1),
    .reg_rs2     (reg_rs2),
    .target_pc   (target_pc),
    .dec_valid   (dec_valid),
    .exec_ready  (exec_ready),
    .dec         (dec),
    .next_pc     (next_pc)
  );

endmodule

`default_nettype wire

// File: decoder_asserts.sv
`default_nettype none

module decoder_asserts
  import rv_isa_pkg::*;
  import decode_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     fetch_valid,
  input logic     fetch_ready,
  input logic     dec_valid,
  input logic     exec_ready,
  input decoded_t dec,
  input word_t    next_pc
);

  timeunit 1ns;
  timeprecision 1ps;

  valid_low_after_reset: assert property (@(posedge clk) reset |=> !dec_valid)
    else $error("dec_valid high in the cycle after reset");

  // held output under back-pressure
  output_held: assert property (@(posedge clk) disable iff (reset)
    dec_valid && !exec_ready |=> dec_valid && $stable(dec) && $stable(next_pc))
    else $error("decoded output changed while stalled");

  accept_to_valid: assert property (@(posedge clk) disable iff (reset)
    fetch_valid && fetch_ready |=> dec_valid)
    else $error("accepted instruction gave no dec_valid one cycle later");

endmodule

bind decode_stage_reg decoder_asserts u_asserts (
  .clk         (clk),
  .reset       (reset),
  .fetch_valid (fetch_valid),
  .fetch_ready (fetch_ready),
  .dec_valid   (dec_valid),
  .exec_ready  (exec_ready),
  .dec         (dec),
  .next_pc     (next_pc)
);

`default_nettype wire

// File: decoder_tb.sv
`default_nettype none

module decoder_tb
  import rv_isa_pkg::*;
  import decode_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 5;

  typedef struct packed {
    instr_u   instr;
    word_t    pc;
    word_t    v1;
    word_t    v2;
    decoded_t exp;
    word_t    npc;
  } row_t;

  logic     clk = 1'b0;
  logic     reset;
  logic     fetch_valid;
  logic     fetch_ready;
  fetch_t   fetch;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    reg_rs1;
  word_t    reg_rs2;
  logic     dec_valid;
  logic     exec_ready;
  decoded_t dec;
  word_t    next_pc;

  word_t       regs [32];
  row_t        rows [$];
  int          seed = 32'h82c6_5f4b;
  logic [31:0] rnd;
  int          in_idx;
  int          out_idx;
  logic        expect_valid;
  int          cycle_count = 0;
  int          cycle_limit = 1000;

  always #50 clk = ~clk;

  // register file answers in the same cycle
  assign reg_rs1 = regs[rs1];
  assign reg_rs2 = regs[rs2];

  rv32_decoder uut (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch       (fetch),
    .rs1         (rs1),
    .rs2         (rs2),
    .reg_rs1     (reg_rs1),
    .reg_rs2     (reg_rs2),
    .dec_valid   (dec_valid),
    .exec_ready  (exec_ready),
    .dec         (dec),
    .next_pc     (next_pc)
  );

  task automatic fail_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_dec(input decoded_t got, input decoded_t exp, input int row);
    if (got !== exp) begin
      $display("[ERROR] time %0t: row %0d got op %s rd %0d a %h b %h addr %h valid %b",
               $time, row, got.op.name(), got.rd, got.operand_a, got.operand_b,
               got.mem_addr, got.valid_instr);
      $display("[ERROR] time %0t: row %0d exp op %s rd %0d a %h b %h addr %h valid %b",
               $time, row, exp.op.name(), exp.rd, exp.operand_a, exp.operand_b,
               exp.mem_addr, exp.valid_instr);
      fail_run();
    end
  endtask

  task automatic check_pc(input word_t got, input word_t exp, input int row);
    if (got !== exp) begin
      $display("[ERROR] time %0t: row %0d next_pc %h, expected %h", $time, row, got, exp);
      fail_run();
    end
  endtask

  task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what,
                           input int row);
    if (got !== exp) begin
      $display("[ERROR] time %0t: row %0d %s index %0d, expected %0d",
               $time, row, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what,
                            input int row);
    if (got !== exp) begin
      $display("[ERROR] time %0t: row %0d %s is %b, expected %b",
               $time, row, what, got, exp);
      fail_run();
    end
  endtask

  // instruction encoders
  function automatic instr_u r_word(input logic [6:0] f7, input reg_idx_t rs2_f, rs1_f,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [4:0] opc);
    r_word = {f7, rs2_f, rs1_f, f3, rd, opc, 2'b11};
  endfunction

  function automatic instr_u i_word(input logic [11:0] imm, input reg_idx_t rs1_f,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [4:0] opc);
    i_word = {imm, rs1_f, f3, rd, opc, 2'b11};
  endfunction

  function automatic instr_u s_word(input logic [11:0] imm, input reg_idx_t rs2_f, rs1_f,
                                    input logic [2:0] f3);
    s_word = {imm[11:5], rs2_f, rs1_f, f3, imm[4:0], opc_store, 2'b11};
  endfunction

  function automatic instr_u b_word(input logic [12:0] off, input reg_idx_t rs2_f, rs1_f,
                                    input logic [2:0] f3);
    b_word = {off[12], off[10:5], rs2_f, rs1_f, f3, off[4:1], off[11], opc_branch, 2'b11};
  endfunction

  function automatic instr_u u_word(input logic [19:0] imm, input reg_idx_t rd,
                                    input logic [4:0] opc);
    u_word = {imm, rd, opc, 2'b11};
  endfunction

  function automatic instr_u j_word(input logic [20:0] off, input reg_idx_t rd);
    j_word = {off[20], off[10:1], off[11], off[19:12], rd, opc_jal, 2'b11};
  endfunction

  task automatic append_row(input instr_u instr, input word_t pc, v1, v2,
                            input dec_op_e op, input reg_idx_t rd,
                            input word_t a, b, addr, input logic valid, input word_t npc);
    row_t r;
    r.instr = instr;
    r.pc = pc;
    r.v1 = v1;
    r.v2 = v2;
    r.exp.op = op;
    r.exp.rd = rd;
    r.exp.operand_a = a;
    r.exp.operand_b = b;
    r.exp.mem_addr = addr;
    r.exp.valid_instr = valid;
    r.npc = npc;
    rows.push_back(r);
  endtask

  task automatic seq_row(input instr_u instr, input word_t pc, v1, v2,
                         input dec_op_e op, input reg_idx_t rd, input word_t a, b, addr);
    append_row(instr, pc, v1, v2, op, rd, a, b, addr, 1'b1, pc + 32'd4);
  endtask

  // branches read x1 and x2
  task automatic branch_row(input logic [2:0] f3, input logic [12:0] off, input word_t pc,
                            input word_t v1, v2, input logic taken);
    word_t npc;
    npc = taken ? pc + {{19{off[12]}}, off} : pc + 32'd4;
    append_row(b_word(off, 5'd2, 5'd1, f3), pc, v1, v2, op_none, 5'd0,
               32'h0, 32'h0, 32'h0, 1'b1, npc);
  endtask

  task automatic build_table();
    seq_row(r_word(funct7_base, 5'd2, 5'd1, f3_add, 5'd3, opc_op), 32'h100,
            32'h10, 32'h22, op_add, 5'd3, 32'h10, 32'h22, 32'h0);
    seq_row(r_word(funct7_alt, 5'd7, 5'd6, f3_add, 5'd5, opc_op), 32'h104,
            32'd100, 32'd200, op_sub, 5'd5, 32'd100, 32'd200, 32'h0);
    seq_row(r_word(funct7_alt, 5'd10, 5'd9, f3_sr, 5'd8, opc_op), 32'h108,
            32'h8000_0000, 32'd3, op_sra, 5'd8, 32'h8000_0000, 32'd3, 32'h0);
    seq_row(r_word(funct7_base, 5'd13, 5'd12, f3_sltu, 5'd11, opc_op), 32'h10c,
            32'd5, 32'hffff_ffff, op_sltu, 5'd11, 32'd5, 32'hffff_ffff, 32'h0);
    seq_row(i_word(12'hff0, 5'd15, f3_and, 5'd14, opc_op_imm), 32'h110,
            32'h1234_5678, 32'h0, op_and, 5'd14, 32'h1234_5678, 32'hffff_fff0, 32'h0);
    // shifts carry the bare shamt
    seq_row(i_word(12'h007, 5'd17, f3_sll, 5'd16, opc_op_imm), 32'h114,
            32'h1, 32'h0, op_sll, 5'd16, 32'h1, 32'd7, 32'h0);
    seq_row(i_word(12'h7ff, 5'd19, f3_xor, 5'd18, opc_op_imm), 32'h118,
            32'haaaa_aaaa, 32'h0, op_xor, 5'd18, 32'haaaa_aaaa, 32'h7ff, 32'h0);
    seq_row(i_word(12'h404, 5'd21, f3_sr, 5'd20, opc_op_imm), 32'h11c,
            32'hf000_0000, 32'h0, op_sra, 5'd20, 32'hf000_0000, 32'd4, 32'h0);
    seq_row(i_word(12'hffc, 5'd2, f3_byte, 5'd1, opc_load), 32'h200,
            32'h1000, 32'h55, op_lb, 5'd1, 32'h1000, 32'h55, 32'h0ffc);
    seq_row(i_word(12'h006, 5'd5, f3_halfu, 5'd4, opc_load), 32'h204,
            32'h2000, 32'h66, op_lhu, 5'd4, 32'h2000, 32'h66, 32'h2006);
    seq_row(i_word(12'h7fc, 5'd8, f3_word, 5'd7, opc_load), 32'h208,
            32'h1_0000, 32'h77, op_lw, 5'd7, 32'h1_0000, 32'h77, 32'h1_07fc);
    seq_row(s_word(12'hfff, 5'd9, 5'd10, f3_byte), 32'h20c,
            32'h3000, 32'hdead_beef, op_sb, 5'd0, 32'h3000, 32'hdead_beef, 32'h2fff);
    seq_row(s_word(12'h040, 5'd11, 5'd12, f3_word), 32'h210,
            32'h4000, 32'h1234_5678, op_sw, 5'd0, 32'h4000, 32'h1234_5678, 32'h4040);
    branch_row(f3_beq, 13'h0010, 32'h300, 32'd7, 32'd7, 1'b1);
    branch_row(f3_beq, 13'h0010, 32'h304, 32'd7, 32'd8, 1'b0);
    branch_row(f3_bne, 13'h1ff8, 32'h308, 32'd1, 32'd2, 1'b1);
    branch_row(f3_bne, 13'h1ff8, 32'h30c, 32'd3, 32'd3, 1'b0);
    branch_row(f3_blt, 13'h0020, 32'h310, 32'hffff_ffff, 32'd1, 1'b1);
    branch_row(f3_blt, 13'h0020, 32'h314, 32'd5, 32'hffff_fffe, 1'b0);
    branch_row(f3_bge, 13'h1f00, 32'h318, 32'd0, 32'hffff_ffff, 1'b1);
    branch_row(f3_bge, 13'h1f00, 32'h31c, 32'h8000_0000, 32'd0, 1'b0);
    // same operands as the taken blt, unsigned this time
    branch_row(f3_bltu, 13'h0040, 32'h320, 32'hffff_ffff, 32'd1, 1'b0);
    branch_row(f3_bltu, 13'h0040, 32'h324, 32'd1, 32'hffff_ffff, 1'b1);
    branch_row(f3_bgeu, 13'h0800, 32'h328, 32'hffff_ffff, 32'd1, 1'b1);
    branch_row(f3_bgeu, 13'h0800, 32'h32c, 32'd2, 32'd3, 1'b0);
    append_row(j_word(21'h0_1000, 5'd1), 32'h400, 32'h0, 32'h0,
               op_add, 5'd1, 32'h400, 32'd4, 32'h0, 1'b1, 32'h1400);
    append_row(j_word(21'h1f_ffe0, 5'd5), 32'h404, 32'h0, 32'h0,
               op_add, 5'd5, 32'h404, 32'd4, 32'h0, 1'b1, 32'h3e4);
    // odd jalr sum, bit 0 dropped
    append_row(i_word(12'h003, 5'd6, f3_jalr, 5'd1, opc_jalr), 32'h408, 32'h1000, 32'h0,
               op_add, 5'd1, 32'h408, 32'd4, 32'h0, 1'b1, 32'h1002);
    seq_row(u_word(20'habcde, 5'd10, opc_lui), 32'h40c,
            32'h0, 32'h0, op_lui, 5'd10, 32'h0, 32'habcd_e000, 32'h0);
    seq_row(u_word(20'h12345, 5'd11, opc_auipc), 32'h410,
            32'h0, 32'h0, op_add, 5'd11, 32'h410, 32'h1234_5000, 32'h0);
    append_row(32'h0000_007f, 32'h500, 32'h0, 32'h0,
               op_none, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h504);
    append_row(r_word(7'b0000001, 5'd2, 5'd1, f3_add, 5'd3, opc_op), 32'h504, 32'd6, 32'd7,
               op_none, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h508);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: %0d of %0d rows came out within %0d cycles",
               out_idx, rows.size(), cycle_limit);
      fail_run();
    end
  end

  initial begin
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch = '0;
    exec_ready = 1'b0;
    foreach (regs[i]) begin
      regs[i] = 32'h0;
    end
    in_idx = 0;
    out_idx = 0;
    expect_valid = 1'b0;
    build_table();
    cycle_limit = 8 * rows.size() + reset_cycles;

    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;

    while (out_idx < rows.size()) begin
      rnd = $random(seed);
      exec_ready = rnd[0];
      if (in_idx < rows.size()) begin
        fetch_valid = 1'b1;
        fetch.instr = rows[in_idx].instr;
        fetch.pc = rows[in_idx].pc;
        regs[rows[in_idx].instr.r.rs1] = rows[in_idx].v1;
        regs[rows[in_idx].instr.r.rs2] = rows[in_idx].v2;
      end else begin
        fetch_valid = 1'b0;
      end

      // sample mid-cycle
      @(negedge clk);
      // ready unless a row is still held for the executor
      check_flag(fetch_ready, out_idx >= in_idx || exec_ready, "fetch_ready", in_idx);
      if (fetch_valid) begin
        check_idx(rs1, rows[in_idx].instr[19:15], "rs1", in_idx);
        check_idx(rs2, rows[in_idx].instr[24:20], "rs2", in_idx);
      end
      if (dec_valid) begin
        if (out_idx >= in_idx) begin
          $display("dec_valid is high but no instruction is waiting to come out");
          fail_run();
        end
        check_dec(dec, rows[out_idx].exp, out_idx);
        check_pc(next_pc, rows[out_idx].npc, out_idx);
        if (exec_ready) begin
          out_idx = out_idx + 1;
        end
      end else if (expect_valid) begin
        $display("dec_valid stayed low one cycle after row %0d was accepted", in_idx - 1);
        fail_run();
      end
      expect_valid = fetch_valid && fetch_ready;
      if (expect_valid) begin
        in_idx = in_idx + 1;
      end

      @(posedge clk);
      #1;
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
rv_isa_pkg.sv
decode_pkg.sv
instr_classifier.sv
imm_gen.sv
branch_unit.sv
decode_stage_reg.sv
rv32_decoder.sv
decoder_asserts.sv
decoder_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  := files.f
TOP       := decoder_tb
RTL_TOP   := rv32_decoder
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard *.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
